// ==== source/risc8_pkg.sv ====
package risc8_pkg;

	// Program counter and data address width
	localparam int addr_w = 16;

	// One data byte
	localparam int data_w = 8;

	// Selects one of 32 registers
	localparam int reg_sel_w = 5;

	// Immediate forms only reach r16 to r31
	localparam int imm_reg_base = 16;

	// Constant operands for COM, INC and DEC
	localparam logic [data_w-1:0] ones_byte = 8'hff;
	localparam logic [data_w-1:0] unit_byte = 8'h01;

	// Status byte bit positions, same layout as the AVR SREG
	localparam int flag_c = 0;
	localparam int flag_z = 1;
	localparam int flag_n = 2;
	localparam int flag_v = 3;
	localparam int flag_s = 4;
	localparam int flag_h = 5;

	// ALU operations
	typedef enum logic [3:0] {
		// Carry in only when use_carry is set
		op_add,
		op_sub,
		op_and,
		op_or,
		op_eor,
		op_lsl,
		op_rol,
		op_lsr,
		op_ror,
		op_asr,
		// Byte move, flags untouched
		op_pass_b,
		// Register pair move for MOVW
		op_pass_word
	} alu_op_t;

	// One instruction word, two field layouts
	typedef union packed {
		// ADD Rd,Rr style: 6-bit group, Rr split around Rd
		struct packed {
			logic [5:0] group;
			logic       rr_hi;
			logic [4:0] rd;
			logic [3:0] rr_lo;
		} reg_form;
		// LDI Rd,K style: K split around a 4-bit Rd
		struct packed {
			logic [3:0] group;
			logic [3:0] k_hi;
			logic [3:0] rd;
			logic [3:0] k_lo;
		} imm_form;
	} opcode_t;

endpackage

// ==== source/risc8_if.sv ====
`timescale 1ns/100ps

// Register file read ports
interface reg_read_if import risc8_pkg::*; ();
	// Selects, driven during decode
	logic [reg_sel_w-1:0] sel_a;
	logic [reg_sel_w-1:0] sel_b;
	// Data one cycle later, data_a is the pair starting at sel_a
	logic [2*data_w-1:0] data_a;
	logic [data_w-1:0]   data_b;

	// STS takes its write byte from data_a
	modport decoder (output sel_a, output sel_b, input data_a);
	modport file (input sel_a, input sel_b, output data_a, output data_b);
	modport operand (input data_a, input data_b);
endinterface

// Stage one controls handed to stage two
interface decode_if import risc8_pkg::*; ();
	alu_op_t              op;
	logic                 use_carry;
	logic                 use_const;
	logic [data_w-1:0]    const_value;
	logic                 store;
	logic                 word;
	logic [reg_sel_w-1:0] dest;

	modport source (output op, use_carry, use_const, const_value, store, word, dest);
	modport sink (input op, use_carry, use_const, const_value, store, word, dest);
endinterface

// Register file write port
interface writeback_if import risc8_pkg::*; ();
	logic                 wen;
	logic                 word;
	logic [reg_sel_w-1:0] dest;
	logic [2*data_w-1:0]  wdata;

	modport source (output wen, word, dest, wdata);
	modport sink (input wen, word, dest, wdata);
endinterface

// ==== source/alu.sv ====
`timescale 1ns/100ps

module alu import risc8_pkg::*; (
	input  alu_op_t             op,
	input  logic                use_carry,
	input  logic [2*data_w-1:0] a,
	input  logic [data_w-1:0]   b,
	input  logic [data_w-1:0]   flags_in,
	output logic [2*data_w-1:0] result,
	output logic [data_w-1:0]   flags_out
);

	logic [data_w-1:0] ra;
	logic [data_w-1:0] r;
	// Ninth bit is carry out or borrow
	logic [data_w:0] sum;
	logic cin;
	logic c;
	logic h;
	logic v;

	always_comb begin
		ra = a[data_w-1:0];
		cin = use_carry & flags_in[flag_c];
		sum = '0;
		r = ra;
		// Unchanged unless the operation says otherwise
		c = flags_in[flag_c];
		h = flags_in[flag_h];
		v = flags_in[flag_v];

		case (op)
		op_add: begin
			sum = {1'b0, ra} + {1'b0, b} + (data_w+1)'(cin);
			r = sum[data_w-1:0];
			c = sum[data_w];
			h = (ra[3] & b[3]) | (b[3] & ~r[3]) | (~r[3] & ra[3]);
			// Same-sign inputs, other-sign result
			v = (ra[7] & b[7] & ~r[7]) | (~ra[7] & ~b[7] & r[7]);
		end
		op_sub: begin
			sum = {1'b0, ra} - {1'b0, b} - (data_w+1)'(cin);
			r = sum[data_w-1:0];
			c = sum[data_w];
			// Borrow out of bit 3
			h = (~ra[3] & b[3]) | (b[3] & r[3]) | (r[3] & ~ra[3]);
			v = (ra[7] & ~b[7] & ~r[7]) | (~ra[7] & b[7] & r[7]);
		end
		op_and: begin
			r = ra & b;
			v = 1'b0;
		end
		op_or: begin
			r = ra | b;
			v = 1'b0;
		end
		op_eor: begin
			r = ra ^ b;
			v = 1'b0;
		end
		op_lsl: begin
			r = {ra[6:0], 1'b0};
			c = ra[7];
			h = ra[3];
			v = r[7] ^ c;
		end
		op_rol: begin
			r = {ra[6:0], cin};
			c = ra[7];
			h = ra[3];
			v = r[7] ^ c;
		end
		op_lsr: begin
			r = {1'b0, ra[7:1]};
			c = ra[0];
			v = r[7] ^ c;
		end
		op_ror: begin
			r = {cin, ra[7:1]};
			c = ra[0];
			v = r[7] ^ c;
		end
		op_asr: begin
			// Sign bit stays put
			r = {ra[7], ra[7:1]};
			c = ra[0];
			v = r[7] ^ c;
		end
		op_pass_b: r = b;
		default: ;
		endcase

		// I and T bits pass through
		flags_out = flags_in;
		flags_out[flag_c] = c;
		flags_out[flag_z] = (r == '0);
		flags_out[flag_n] = r[7];
		flags_out[flag_v] = v;
		flags_out[flag_s] = r[7] ^ v;
		flags_out[flag_h] = h;

		// MOVW returns the whole pair
		result = (op == op_pass_word) ? a : {{data_w{1'b0}}, r};
	end

endmodule

// ==== source/execute_stage.sv ====
`timescale 1ns/100ps

module execute_stage import risc8_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	decode_if.sink      dec,
	reg_read_if.operand rd,
	writeback_if.source wb
);

	// Decode bundle, one cycle behind
	alu_op_t op_q;
	logic carry_q;
	logic const_q;
	logic [data_w-1:0] const_value_q;
	logic store_q;
	logic word_q;
	logic [reg_sel_w-1:0] dest_q;

	logic [data_w-1:0] sreg;
	logic [data_w-1:0] sreg_next;
	logic [data_w-1:0] operand_b;
	logic [2*data_w-1:0] result;
	logic flags_change;

	always_ff @(posedge clk) begin
		if (reset) begin
			op_q <= op_pass_b;
			store_q <= 1'b0;
		end else begin
			op_q <= dec.op;
			store_q <= dec.store;
		end
		carry_q <= dec.use_carry;
		const_q <= dec.use_const;
		const_value_q <= dec.const_value;
		word_q <= dec.word;
		dest_q <= dec.dest;
	end

	// Immediate, fixed constant or Rr
	assign operand_b = const_q ? const_value_q : rd.data_b;

	alu alu_i (
		.op        (op_q),
		.use_carry (carry_q),
		.a         (rd.data_a),
		.b         (operand_b),
		.flags_in  (sreg),
		.result    (result),
		.flags_out (sreg_next)
	);

	// Moves, LDI and LDS leave flags alone
	assign flags_change = !(op_q inside {op_pass_b, op_pass_word});

	always_ff @(posedge clk) begin
		if (reset)
			sreg <= '0;
		else if (flags_change)
			sreg <= sreg_next;
	end

	assign wb.wen = store_q;
	assign wb.word = word_q;
	assign wb.dest = dest_q;
	assign wb.wdata = result;

endmodule

// ==== source/reg_file.sv ====
`timescale 1ns/100ps

module reg_file import risc8_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	reg_read_if.file rd,
	writeback_if.sink wb
);

	logic [data_w-1:0] regs [1<<reg_sel_w];
	// Odd half of a pair write
	logic [reg_sel_w-1:0] dest_hi;

	assign dest_hi = wb.dest | reg_sel_w'(1);

	// Register byte, or the byte being written this cycle
	function automatic logic [data_w-1:0] read_byte(input logic [reg_sel_w-1:0] sel);
		if (wb.wen && sel == wb.dest)
			return wb.wdata[data_w-1:0];
		if (wb.wen && wb.word && sel == dest_hi)
			return wb.wdata[2*data_w-1:data_w];
		return regs[sel];
	endfunction

	always_ff @(posedge clk) begin
		if (wb.wen) begin
			regs[wb.dest] <= wb.wdata[data_w-1:0];
			// MOVW fills both halves
			if (wb.word)
				regs[dest_hi] <= wb.wdata[2*data_w-1:data_w];
		end
	end

	// Read data lands one cycle after the selects
	always_ff @(posedge clk) begin
		if (reset) begin
			rd.data_a <= '0;
			rd.data_b <= '0;
		end else begin
			rd.data_a <= {read_byte(rd.sel_a + reg_sel_w'(1)), read_byte(rd.sel_a)};
			rd.data_b <= read_byte(rd.sel_b);
		end
	end

endmodule

// ==== source/decode_stage.sv ====
`timescale 1ns/100ps

module decode_stage import risc8_pkg::*; (
	input  logic              clk,
	input  logic              reset,
	output logic [addr_w-1:0] pc,
	input  logic [15:0]       cdata,
	input  logic [data_w-1:0] data_read,
	output logic [addr_w-1:0] data_addr,
	output logic              data_wen,
	output logic              data_ren,
	output logic [data_w-1:0] data_write,
	reg_read_if.decoder       rd,
	decode_if.source          dec
);

	// Address of the word now on cdata
	logic [addr_w-1:0] pc_q;
	logic [addr_w-1:0] next_pc;
	// 0 normal, 1 address word, 2 LDS data
	logic [1:0] step;
	logic [1:0] next_step;
	logic [15:0] saved_op;
	opcode_t opcode;
	logic [reg_sel_w-1:0] op_rr;
	logic [reg_sel_w-1:0] op_rdi;
	logic [data_w-1:0] op_k;
	logic imm_alu;

	// Later steps of LDS and STS reuse the first opcode
	assign opcode = (step == 2'd0) ? cdata : saved_op;

	assign op_rr = {opcode.reg_form.rr_hi, opcode.reg_form.rr_lo};
	// Immediate Rd is offset into the upper half
	assign op_rdi = reg_sel_w'(imm_reg_base) | reg_sel_w'(opcode.imm_form.rd);
	assign op_k = {opcode.imm_form.k_hi, opcode.imm_form.k_lo};

	// Fetch holds only while LDS waits for its byte
	assign next_pc = (step == 2'd2) ? pc_q : pc_q + addr_w'(1);
	assign pc = next_pc;

	always_ff @(posedge clk) begin
		if (reset) begin
			// First fetch wraps around to word 0
			pc_q <= '1;
			step <= 2'd0;
		end else begin
			pc_q <= next_pc;
			step <= next_step;
		end
		saved_op <= opcode;
	end

	always_comb begin
		next_step = 2'd0;
		data_addr = '0;
		data_wen = 1'b0;
		data_ren = 1'b0;
		data_write = '0;
		imm_alu = 1'b0;

		// Default Rd,Rr reads, writing back to Rd
		rd.sel_a = opcode.reg_form.rd;
		rd.sel_b = op_rr;

		// Anything unmatched falls through as a NOP
		dec.op = op_pass_b;
		dec.use_carry = 1'b0;
		dec.use_const = 1'b0;
		dec.const_value = '0;
		dec.store = 1'b0;
		dec.word = 1'b0;
		dec.dest = opcode.reg_form.rd;

		case (step)
		2'd0: begin
			// Two-register group
			case (opcode.reg_form.group)
			6'b000001: begin
				// CPC, flags only
				dec.op = op_sub;
				dec.use_carry = 1'b1;
			end
			6'b000010: begin
				// SBC
				dec.op = op_sub;
				dec.use_carry = 1'b1;
				dec.store = 1'b1;
			end
			6'b000011: begin
				// ADD, or LSL when Rd equals Rr
				dec.op = (opcode.reg_form.rd == op_rr) ? op_lsl : op_add;
				dec.store = 1'b1;
			end
			6'b000101: dec.op = op_sub;
			6'b000110: begin
				// SUB
				dec.op = op_sub;
				dec.store = 1'b1;
			end
			6'b000111: begin
				// ADC, or ROL when Rd equals Rr
				dec.op = (opcode.reg_form.rd == op_rr) ? op_rol : op_add;
				dec.use_carry = 1'b1;
				dec.store = 1'b1;
			end
			6'b001000: begin
				dec.op = op_and;
				dec.store = 1'b1;
			end
			6'b001001: begin
				dec.op = op_eor;
				dec.store = 1'b1;
			end
			6'b001010: begin
				dec.op = op_or;
				dec.store = 1'b1;
			end
			// MOV keeps the default byte move
			6'b001011: dec.store = 1'b1;
			default: ;
			endcase

			// Immediate group, same word through the K/Rd view
			case (opcode.imm_form.group)
			4'b0011: begin
				// CPI
				dec.op = op_sub;
				imm_alu = 1'b1;
			end
			4'b0100: begin
				// SBCI
				dec.op = op_sub;
				dec.use_carry = 1'b1;
				dec.store = 1'b1;
				imm_alu = 1'b1;
			end
			4'b0101: begin
				// SUBI
				dec.op = op_sub;
				dec.store = 1'b1;
				imm_alu = 1'b1;
			end
			4'b0110: begin
				dec.op = op_or;
				dec.store = 1'b1;
				imm_alu = 1'b1;
			end
			4'b0111: begin
				dec.op = op_and;
				dec.store = 1'b1;
				imm_alu = 1'b1;
			end
			4'b1110: begin
				// LDI, constant passes straight through
				dec.store = 1'b1;
				imm_alu = 1'b1;
			end
			default: ;
			endcase

			if (imm_alu) begin
				rd.sel_a = op_rdi;
				dec.dest = op_rdi;
				dec.use_const = 1'b1;
				dec.const_value = op_k;
			end

			// One-operand group, sub-op in the low nibble
			if (opcode.reg_form.group == 6'b100101 && !opcode.reg_form.rr_hi) begin
				case (opcode.reg_form.rr_lo)
				4'b0000: begin
					// COM as EOR with all ones
					dec.op = op_eor;
					dec.use_const = 1'b1;
					dec.const_value = ones_byte;
					dec.store = 1'b1;
				end
				4'b0011: begin
					// INC
					dec.op = op_add;
					dec.use_const = 1'b1;
					dec.const_value = unit_byte;
					dec.store = 1'b1;
				end
				4'b0101: begin
					dec.op = op_asr;
					dec.store = 1'b1;
				end
				4'b0110: begin
					dec.op = op_lsr;
					dec.store = 1'b1;
				end
				4'b0111: begin
					// ROR shifts C in from the top
					dec.op = op_ror;
					dec.use_carry = 1'b1;
					dec.store = 1'b1;
				end
				4'b1010: begin
					// DEC
					dec.op = op_sub;
					dec.use_const = 1'b1;
					dec.const_value = unit_byte;
					dec.store = 1'b1;
				end
				default: ;
				endcase
			end

			// MOVW, pair numbers are doubled
			if (opcode.reg_form.group == 6'b000000 && !opcode.reg_form.rr_hi
					&& opcode.reg_form.rd[4]) begin
				rd.sel_a = {opcode.imm_form.k_lo, 1'b0};
				dec.dest = {opcode.imm_form.rd, 1'b0};
				dec.op = op_pass_word;
				dec.word = 1'b1;
				dec.store = 1'b1;
			end

			// LDS/STS, address arrives in the next word
			// STS reads Rd here so data_a is ready next cycle
			if (opcode.reg_form.group == 6'b100100 && opcode.reg_form.rr_lo == 4'b0000)
				next_step = 2'd1;
		end
		2'd1: begin
			data_addr = cdata;
			if (opcode.reg_form.rr_hi) begin
				// STS write, done in two cycles
				data_wen = 1'b1;
				data_write = rd.data_a[data_w-1:0];
			end else begin
				// LDS read, byte comes back next cycle
				data_ren = 1'b1;
				next_step = 2'd2;
			end
		end
		2'd2: begin
			// LDS byte goes to Rd like LDI
			dec.use_const = 1'b1;
			dec.const_value = data_read;
			dec.store = 1'b1;
		end
		default: ;
		endcase
	end

endmodule

// ==== source/risc8_cpu.sv ====
`timescale 1ns/100ps

module risc8_cpu import risc8_pkg::*; (
	input  logic              clk,
	input  logic              reset,
	// Program memory, one word per cycle
	output logic [addr_w-1:0] pc,
	input  logic [15:0]       cdata,
	// Data memory, fixed one-cycle read
	output logic [addr_w-1:0] data_addr,
	output logic              data_wen,
	output logic              data_ren,
	input  logic [data_w-1:0] data_read,
	output logic [data_w-1:0] data_write
);

	reg_read_if  rd_bus ();
	decode_if    dec_bus ();
	writeback_if wb_bus ();

	// Stage one, fetch sequencing and decode
	decode_stage decode_i (
		.clk        (clk),
		.reset      (reset),
		.pc         (pc),
		.cdata      (cdata),
		.data_read  (data_read),
		.data_addr  (data_addr),
		.data_wen   (data_wen),
		.data_ren   (data_ren),
		.data_write (data_write),
		.rd         (rd_bus),
		.dec        (dec_bus)
	);

	// Registered reads, forwarded writes
	reg_file reg_file_i (
		.clk   (clk),
		.reset (reset),
		.rd    (rd_bus),
		.wb    (wb_bus)
	);

	// Stage two, ALU and status byte
	execute_stage execute_i (
		.clk   (clk),
		.reset (reset),
		.dec   (dec_bus),
		.rd    (rd_bus),
		.wb    (wb_bus)
	);

endmodule

// ==== sim/risc8_check.sv ====
`timescale 1ns/100ps

module risc8_check import risc8_pkg::*; (
	input logic              clk,
	input logic              data_wen,
	input logic              data_ren,
	input logic [addr_w-1:0] data_addr,
	input logic [data_w-1:0] data_write
);

	// Stores still owed by the running test in order
	logic [addr_w-1:0] exp_addr [$];
	logic [data_w-1:0] exp_data [$];
	// LDS reads still owed, one per preloaded byte
	logic [addr_w-1:0] exp_load [$];
	string name = "none";
	int test_errors = 0;
	int total_errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;

	task automatic start_test(input string test);
		name = test;
		test_errors = 0;
		exp_addr.delete();
		exp_data.delete();
		exp_load.delete();
	endtask

	task automatic expect_store(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
	endtask

	task automatic expect_load(input logic [addr_w-1:0] addr);
		exp_load.push_back(addr);
	endtask

	function automatic int pending();
		return exp_addr.size() + exp_load.size();
	endfunction

	// One result line per test
	// Stores or loads still owed at the end mean a timeout
	task automatic finish_test(input int limit);
		if (pending() > 0) begin
			$display("Timeout in %s: %0d stores and %0d loads still missing after %0d cycles",
				name, exp_addr.size(), exp_load.size(), limit);
			test_errors++;
		end
		total_errors += test_errors;
		if (test_errors == 0) begin
			tests_passed++;
			$display("%s: passed", name);
		end else begin
			tests_failed++;
			$display("%s: failed with %0d errors", name, test_errors);
		end
	endtask

	task automatic report_counts();
		$display("Tests %0d, passed %0d, failed %0d, errors %0d",
			tests_passed + tests_failed, tests_passed, tests_failed, total_errors);
	endtask

	// Stores and load requests are strobe pulses seen at the rising edge
	always @(posedge clk) begin
		logic [addr_w-1:0] want_addr;
		logic [data_w-1:0] want_data;
		logic [addr_w-1:0] want_load;
		if (data_wen) begin
			if (exp_addr.size() == 0) begin
				$display("Unexpected store in %s: %h written to address %h",
					name, data_write, data_addr);
				test_errors++;
			end else begin
				want_addr = exp_addr.pop_front();
				want_data = exp_data.pop_front();
				if (data_addr !== want_addr) begin
					$display("Fail %s: store address expected %h, actual %h",
						name, want_addr, data_addr);
					test_errors++;
				end
				if (data_write !== want_data) begin
					$display("Fail %s: byte at %h expected %h, actual %h",
						name, want_addr, want_data, data_write);
					test_errors++;
				end
			end
		end
		if (data_ren) begin
			if (exp_load.size() == 0) begin
				$display("Unexpected load in %s from address %h", name, data_addr);
				test_errors++;
			end else begin
				want_load = exp_load.pop_front();
				if (data_addr !== want_load) begin
					$display("Fail %s: load address expected %h, actual %h",
						name, want_load, data_addr);
					test_errors++;
				end
			end
		end
	end

endmodule

// ==== sim/risc8_tb.sv ====
`timescale 1ns/100ps

module risc8_tb import risc8_pkg::*; ();

	localparam int pat_depth = 256;
	localparam int prog_depth = 256;
	localparam int dmem_depth = 4096;
	localparam int reset_cycles = 10;
	// Idle cycles after the last store to catch extra stores
	localparam int drain_cycles = 4;

	logic clk = 1'b0;
	logic reset;
	logic [addr_w-1:0] pc;
	logic [15:0] cdata = '0;
	logic [addr_w-1:0] data_addr;
	logic data_wen;
	logic data_ren;
	logic [data_w-1:0] data_read = '0;
	logic [data_w-1:0] data_write;

	logic [31:0] patterns [pat_depth];
	logic [15:0] prog [prog_depth];
	logic [data_w-1:0] dmem [dmem_depth];
	// Requests as seen at the last rising edge
	logic [addr_w-1:0] fetch_addr = '0;
	logic [addr_w-1:0] load_addr = '0;
	logic load_pending = 1'b0;

	always #2 clk = ~clk;

	risc8_cpu risc8_cpu_i (
		.clk        (clk),
		.reset      (reset),
		.pc         (pc),
		.cdata      (cdata),
		.data_addr  (data_addr),
		.data_wen   (data_wen),
		.data_ren   (data_ren),
		.data_read  (data_read),
		.data_write (data_write)
	);

	risc8_check check_i (
		.clk        (clk),
		.data_wen   (data_wen),
		.data_ren   (data_ren),
		.data_addr  (data_addr),
		.data_write (data_write)
	);

	always @(posedge clk) begin
		fetch_addr <= pc;
		load_addr <= data_addr;
		load_pending <= data_ren;
	end

	// Both memories answer on the falling edge
	always @(negedge clk) begin
		cdata <= prog[fetch_addr[7:0]];
		if (load_pending)
			data_read <= dmem[load_addr[11:0]];
	end

	function automatic string test_name(input int num);
		case (num)
		1: return "ldi_sts";
		2: return "alu_chain";
		3: return "carry_chain";
		4: return "one_operand";
		5: return "movw_lds";
		default: return $sformatf("test_%0d", num);
		endcase
	endfunction

	// Unused program words are NOPs
	task automatic clear_memories();
		for (int i = 0; i < prog_depth; i++)
			prog[i] = 16'h0000;
		for (int i = 0; i < dmem_depth; i++)
			dmem[i] = 8'(i) ^ 8'(i >> 4);
	endtask

	initial begin
		int idx;
		int prog_len;
		int limit;
		int cycles;
		int tests_run;
		logic [31:0] rec;

		reset = 1'b1;
		idx = 0;
		tests_run = 0;
		for (int i = 0; i < pat_depth; i++)
			patterns[i] = 32'hf0000000;
		$readmemh("sim/risc8_patterns.mem", patterns);

		while (idx < pat_depth && patterns[idx][31:28] == 4'h1) begin
			@(negedge clk);
			reset = 1'b1;
			clear_memories();
			check_i.start_test(test_name(int'(patterns[idx][7:0])));
			idx++;
			prog_len = 0;
			// Program words, expected stores and preloads up to the next test
			while (idx < pat_depth && patterns[idx][31:28] inside {4'h2, 4'h3, 4'h4}) begin
				rec = patterns[idx];
				case (rec[31:28])
				4'h2: begin
					if (prog_len < prog_depth)
						prog[prog_len] = rec[15:0];
					prog_len++;
				end
				4'h3: check_i.expect_store(rec[23:8], rec[7:0]);
				default: begin
					dmem[rec[19:8]] = rec[7:0];
					// Each preloaded byte is read once by an LDS
					check_i.expect_load(rec[23:8]);
				end
				endcase
				idx++;
			end
			repeat (reset_cycles) @(negedge clk);
			reset = 1'b0;

			limit = 4 * prog_len + 20;
			cycles = 0;
			while (check_i.pending() > 0 && cycles < limit) begin
				@(negedge clk);
				cycles++;
			end
			repeat (drain_cycles) @(negedge clk);
			check_i.finish_test(limit);
			tests_run++;
		end

		if (tests_run == 0)
			$display("No test records found in the pattern file");
		check_i.report_counts();
		if (tests_run > 0 && check_i.total_errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// ==== sim/risc8_patterns.mem ====
// One 32-bit hex record per word, top nibble is the kind
// 1 test number, 2 program word, 3 store 0 aaaa dd, 4 preload 0 aaaa dd, f end
// LDI into r16 and r31, then STS of both
10000001
20000000 2000e30c 2000eaf5 20009300 20000100 200093f0 20000101
3001003c 300101a5
// ADD SUB AND OR EOR on r16, MOV r18, SUBI and ANDI on r17
10000002
20000000 2000e305 2000e11a 20000f01 20001b01 20002301 20002b01 20002701
20002f21 20005015 2000701f 20009300 20000200 20009310 20000201 20009320
20000202
30020000 30020105 3002021a
// 16-bit add and subtract, then CP and CPC exposed by ADC of zeros
10000003
20000000 2000ef00 2000e112 2000e220 2000e035 20000f02 20001f13 20009300
20000300 20009310 20000301 20001b02 20000b13 20009300 20000302 20009310
20000303 2000e040 2000e050 20001720 20000733 20001f45 20009340 20000304
30030010 30030118 300302f0 30030312 30030401
// COM INC DEC LSL ROL LSR ROR ASR on r16
10000004
20000000 2000e906 20009500 20009300 20000400 20009503 20009300 20000401
2000950a 20000f00 20009300 20000402 20000f00 20001f00 20009300 20000403
20009506 20009507 20009300 20000404 20009505 20009300 20000405
30040069 3004016a 300402d2 30040349 30040492 300405c9
// MOVW r3:r2 from r19:r18, LDS r20 from 0x0600 and store it back
10000005
4006007e
20000000 2000e52b 2000ec34 20000119 20009220 20000500 20009230 20000501
20009140 20000600 20009340 20000502
3005005b 300501c4 3005027e
f0000000

// ==== risc8_cpu.f ====
source/risc8_pkg.sv
source/risc8_if.sv
source/alu.sv
source/execute_stage.sv
source/reg_file.sv
source/decode_stage.sv
source/risc8_cpu.sv
sim/risc8_check.sv
sim/risc8_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= risc8_tb
FILELIST ?= risc8_cpu.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing

BIN := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)
